/* common/key_extract_pkg.sv */
// key extractor package: PHV layout, widths, types, control header fields, writer states
package key_extract_pkg;

    // container geometry
    localparam int NUM_CONT = 8;
    localparam int CONT6_W  = 48;
    localparam int CONT4_W  = 32;
    localparam int CONT2_W  = 16;

    // opcodes and metadata, at the bottom of the PHV
    localparam int META_W  = 256;
    localparam int OP_W    = 20;
    localparam int NUM_OPS = 5;

    // msb of opcode 0, opcode 0 is the highest of the five
    localparam int OP_BASE   = META_W + NUM_OPS * OP_W - 1;
    localparam int CONT2_LSB = OP_BASE + 1;
    localparam int CONT4_LSB = CONT2_LSB + NUM_CONT * CONT2_W;
    localparam int CONT6_LSB = CONT4_LSB + NUM_CONT * CONT4_W;
    localparam int PHV_W     = CONT6_LSB + NUM_CONT * CONT6_W;

    // vlan id inside the metadata
    localparam int VLAN_LSB = 129;
    localparam int VLAN_W   = 12;

    // key is two 6B, two 4B, two 2B fields and one bit per stage comparator
    localparam int KEY_CMP_W = 5;
    localparam int KEY_W     = 2 * CONT6_W + 2 * CONT4_W + 2 * CONT2_W + KEY_CMP_W;
    localparam int KEY_OFF_W = 18;

    // control beat header, little endian positions on the raw beat
    localparam int CTRL_W     = 512;
    localparam int MOD_ID_LSB = 368;
    localparam int RESV_LSB   = 380;
    localparam int FLAG_LSB   = 320;
    localparam int INDEX_LSB  = 384;
    localparam logic [15:0] CTRL_FLAG_KEY = 16'hf2f1;

    localparam int NUM_ENTRIES = 16;

    typedef logic [PHV_W-1:0]     phv_t;
    typedef logic [CONT6_W-1:0]   cont6_t;
    typedef logic [CONT4_W-1:0]   cont4_t;
    typedef logic [CONT2_W-1:0]   cont2_t;
    typedef logic [KEY_W-1:0]     key_t;
    typedef logic [KEY_OFF_W-1:0] key_off_t;
    typedef logic [OP_W-1:0]      com_op_t;
    typedef logic [3:0]           tbl_addr_t;
    typedef logic [7:0]           cfg_index_t;
    typedef logic [CTRL_W-1:0]    ctrl_data_t;

    typedef enum logic [1:0] {
        CFG_IDLE,
        CFG_WR_OFF,
        CFG_WR_MASK
    } cfg_state_t;

endpackage

/* common/table_wr_if.sv */
// table write interface between the configuration writer and the key table
`timescale 1ns/1ns

interface table_wr_if;

    // single-cycle strobes, never high together
    logic                        wr_off;
    logic                        wr_mask;
    key_extract_pkg::tbl_addr_t  wr_index;
    // offset table uses the top KEY_OFF_W bits
    key_extract_pkg::key_t       wr_data;

    modport writer (
        output wr_off, wr_mask, wr_index, wr_data
    );

    modport tbl (
        input wr_off, wr_mask, wr_index, wr_data
    );

endinterface

/* hdl/cfg_writer.sv */
// cfg_writer: control stream header match, burst index counter and table write strobes
`timescale 1ns/1ns

module cfg_writer #(
    parameter int         STAGE_ID  = 0,
    parameter logic [2:0] KEY_EX_ID = 3'd1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  key_extract_pkg::ctrl_data_t     ctrl_data,
    input  logic                            ctrl_valid,
    input  logic                            ctrl_last,
    table_wr_if.writer                      wr
);

    localparam int CTRL_W = key_extract_pkg::CTRL_W;

    key_extract_pkg::cfg_state_t  state;
    key_extract_pkg::cfg_index_t  index;
    key_extract_pkg::ctrl_data_t  swapped;
    logic [7:0]                   mod_id;
    logic [3:0]                   resv;
    logic [15:0]                  ctrl_flag;
    logic                         hdr_match;

    assign mod_id    = ctrl_data[key_extract_pkg::MOD_ID_LSB +: 8];
    assign resv      = ctrl_data[key_extract_pkg::RESV_LSB +: 4];
    assign ctrl_flag = ctrl_data[key_extract_pkg::FLAG_LSB +: 16];

    // upper five bits pick the stage, lower three the extractor in it
    // a header that is also the last beat carries no entries
    assign hdr_match = ctrl_valid && !ctrl_last
                    && (mod_id[7:3] == 5'(STAGE_ID))
                    && (mod_id[2:0] == KEY_EX_ID)
                    && (ctrl_flag == key_extract_pkg::CTRL_FLAG_KEY);

    // beats arrive little endian, tables are written big endian
    always_comb begin
        for (int b = 0; b < CTRL_W / 8; b++) begin
            swapped[CTRL_W-1-8*b -: 8] = ctrl_data[8*b +: 8];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= key_extract_pkg::CFG_IDLE;
            index      <= '0;
            wr.wr_off  <= 1'b0;
            wr.wr_mask <= 1'b0;
        end else begin
            wr.wr_off  <= 1'b0;
            wr.wr_mask <= 1'b0;
            case (state)
                key_extract_pkg::CFG_IDLE: begin
                    if (hdr_match) begin
                        index <= ctrl_data[key_extract_pkg::INDEX_LSB +: 8];
                        // nonzero reserved nibble selects the mask table
                        if (resv != 4'd0) begin
                            state <= key_extract_pkg::CFG_WR_MASK;
                        end else begin
                            state <= key_extract_pkg::CFG_WR_OFF;
                        end
                    end
                end
                key_extract_pkg::CFG_WR_OFF,
                key_extract_pkg::CFG_WR_MASK: begin
                    if (ctrl_valid) begin
                        wr.wr_off  <= (state == key_extract_pkg::CFG_WR_OFF);
                        wr.wr_mask <= (state == key_extract_pkg::CFG_WR_MASK);
                        index      <= index + 8'd1;
                        if (ctrl_last) begin
                            state <= key_extract_pkg::CFG_IDLE;
                        end
                    end
                end
                default: begin
                    state <= key_extract_pkg::CFG_IDLE;
                end
            endcase
        end
    end

    // address and data follow the strobe by the same cycle
    always_ff @(posedge clk) begin
        if (ctrl_valid && (state != key_extract_pkg::CFG_IDLE)) begin
            wr.wr_index <= key_extract_pkg::tbl_addr_t'(index);
            wr.wr_data  <= swapped[CTRL_W-1 -: key_extract_pkg::KEY_W];
        end
    end

endmodule

/* hdl/key_extract.sv */
// key_extract: top level of the key extractor, writer, tables and assembler
`timescale 1ns/1ns

module key_extract #(
    parameter int         STAGE_ID  = 0,
    parameter logic [2:0] KEY_EX_ID = 3'd1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // data path
    input  key_extract_pkg::phv_t         phv_in,
    input  logic                          phv_valid,
    output key_extract_pkg::phv_t         phv_out,
    output logic                          phv_out_valid,
    output key_extract_pkg::key_t         key_out,
    output logic                          key_valid,
    output key_extract_pkg::key_t         key_mask,
    // configuration stream
    input  key_extract_pkg::ctrl_data_t   ctrl_data,
    input  logic                          ctrl_valid,
    input  logic                          ctrl_last
);

    key_extract_pkg::tbl_addr_t  rd_addr;
    key_extract_pkg::key_off_t   rd_off;
    key_extract_pkg::key_t       rd_mask;

    table_wr_if tbl_wr ();

    cfg_writer #(
        .STAGE_ID  (STAGE_ID),
        .KEY_EX_ID (KEY_EX_ID)
    ) u_cfg_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl_data  (ctrl_data),
        .ctrl_valid (ctrl_valid),
        .ctrl_last  (ctrl_last),
        .wr         (tbl_wr.writer)
    );

    key_table_ram u_key_table_ram (
        .clk     (clk),
        .wr      (tbl_wr.tbl),
        .rd_addr (rd_addr),
        .rd_off  (rd_off),
        .rd_mask (rd_mask)
    );

    key_assembler #(
        .STAGE_ID (STAGE_ID)
    ) u_key_assembler (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid     (phv_valid),
        .rd_addr       (rd_addr),
        .rd_off        (rd_off),
        .rd_mask       (rd_mask),
        .phv_out       (phv_out),
        .phv_out_valid (phv_out_valid),
        .key_out       (key_out),
        .key_valid     (key_valid),
        .key_mask      (key_mask)
    );

endmodule

/* hdl/key_table_ram.sv */
// key_table_ram: 16-entry offset and mask tables, one write port and registered read each
`timescale 1ns/1ns

module key_table_ram (
    input  logic                          clk,
    table_wr_if.tbl                       wr,
    input  key_extract_pkg::tbl_addr_t    rd_addr,
    output key_extract_pkg::key_off_t     rd_off,
    output key_extract_pkg::key_t         rd_mask
);

    localparam int KEY_W     = key_extract_pkg::KEY_W;
    localparam int KEY_OFF_W = key_extract_pkg::KEY_OFF_W;

    key_extract_pkg::key_off_t  off_mem  [key_extract_pkg::NUM_ENTRIES];
    key_extract_pkg::key_t      mask_mem [key_extract_pkg::NUM_ENTRIES];

    // offset word sits in the top bits of the swapped beat
    always_ff @(posedge clk) begin
        if (wr.wr_off) begin
            off_mem[wr.wr_index] <= wr.wr_data[KEY_W-1 -: KEY_OFF_W];
        end
    end

    always_ff @(posedge clk) begin
        if (wr.wr_mask) begin
            mask_mem[wr.wr_index] <= wr.wr_data;
        end
    end

    // read is old data when the same entry is written on the same edge
    always_ff @(posedge clk) begin
        rd_off  <= off_mem[rd_addr];
        rd_mask <= mask_mem[rd_addr];
    end

endmodule

/* key_build/key_assembler.sv */
// key_assembler: container slicing, key field select, comparator bit, PHV and mask alignment
`timescale 1ns/1ns

module key_assembler #(
    parameter int STAGE_ID = 0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  key_extract_pkg::phv_t         phv_in,
    input  logic                          phv_valid,
    output key_extract_pkg::tbl_addr_t    rd_addr,
    input  key_extract_pkg::key_off_t     rd_off,
    input  key_extract_pkg::key_t         rd_mask,
    output key_extract_pkg::phv_t         phv_out,
    output logic                          phv_out_valid,
    output key_extract_pkg::key_t         key_out,
    output logic                          key_valid,
    output key_extract_pkg::key_t         key_mask
);

    localparam int NUM_CONT = key_extract_pkg::NUM_CONT;
    localparam int CONT6_W  = key_extract_pkg::CONT6_W;
    localparam int CONT4_W  = key_extract_pkg::CONT4_W;
    localparam int CONT2_W  = key_extract_pkg::CONT2_W;
    // msb of this stage's opcode
    localparam int OP_MSB   = key_extract_pkg::OP_BASE - STAGE_ID * key_extract_pkg::OP_W;
    localparam int CMP_BIT  = 4 - STAGE_ID;

    logic [key_extract_pkg::VLAN_W-1:0]  vlan_id;
    key_extract_pkg::cont6_t   c6_q [NUM_CONT];
    key_extract_pkg::cont4_t   c4_q [NUM_CONT];
    key_extract_pkg::cont2_t   c2_q [NUM_CONT];
    key_extract_pkg::com_op_t  op_q;
    key_extract_pkg::phv_t     phv_q;
    logic                      valid_q;
    logic [7:0]                opnd_a;
    logic [7:0]                opnd_b;
    logic                      cmp_bit;
    key_extract_pkg::key_t     key_d;

    // 9-bit operand field: imm flag, then imm byte or size code and index
    function automatic logic [7:0] pick_operand(input logic [8:0] fld);
        logic [7:0] val;
        val = 8'd0;
        if (fld[8]) begin
            val = fld[7:0];
        end else begin
            case (fld[4:3])
                2'b10:   val = c6_q[fld[2:0]][7:0];
                2'b01:   val = c4_q[fld[2:0]][7:0];
                2'b00:   val = c2_q[fld[2:0]][7:0];
                default: val = 8'd0;
            endcase
        end
        return val;
    endfunction

    // tenant select, table read runs alongside stage 1
    assign vlan_id = phv_in[key_extract_pkg::VLAN_LSB +: key_extract_pkg::VLAN_W];
    assign rd_addr = vlan_id[7:4];

    // stage 1
    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_CONT; k++) begin
            c6_q[k] <= phv_in[key_extract_pkg::CONT6_LSB + k*CONT6_W +: CONT6_W];
            c4_q[k] <= phv_in[key_extract_pkg::CONT4_LSB + k*CONT4_W +: CONT4_W];
            c2_q[k] <= phv_in[key_extract_pkg::CONT2_LSB + k*CONT2_W +: CONT2_W];
        end
        op_q  <= phv_in[OP_MSB -: key_extract_pkg::OP_W];
        phv_q <= phv_in;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= phv_valid;
        end
    end

    always_comb begin
        opnd_a = pick_operand(op_q[17:9]);
        opnd_b = pick_operand(op_q[8:0]);
        case (op_q[19:18])
            2'b00:   cmp_bit = (opnd_a > opnd_b);
            2'b01:   cmp_bit = (opnd_a >= opnd_b);
            2'b10:   cmp_bit = (opnd_a == opnd_b);
            default: cmp_bit = 1'b1;
        endcase
    end

    // offset order is 6B, 6B, 4B, 4B, 2B, 2B from the msb down
    always_comb begin
        key_d = {c6_q[rd_off[17:15]], c6_q[rd_off[14:12]],
                 c4_q[rd_off[11:9]],  c4_q[rd_off[8:6]],
                 c2_q[rd_off[5:3]],   c2_q[rd_off[2:0]],
                 {key_extract_pkg::KEY_CMP_W{1'b0}}};
        key_d[CMP_BIT] = cmp_bit;
    end

    // stage 2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_out       <= '0;
            key_valid     <= 1'b0;
            phv_out_valid <= 1'b0;
        end else begin
            key_valid     <= valid_q;
            phv_out_valid <= valid_q;
            key_out       <= valid_q ? key_d : '0;
        end
    end

    always_ff @(posedge clk) begin
        phv_out  <= phv_q;
        key_mask <= rd_mask;
    end

endmodule

/* sim/key_extract_checker.sv */
// key_extract_checker: table model, expected key, mask and PHV queues, output comparison
`timescale 1ns/1ns

module key_extract_checker #(
    parameter int         STAGE_ID  = 0,
    parameter logic [2:0] KEY_EX_ID = 3'd1
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  key_extract_pkg::phv_t        phv_in,
    input  logic                         phv_valid,
    input  logic                         exp_cmp,
    input  key_extract_pkg::ctrl_data_t  ctrl_data,
    input  logic                         ctrl_valid,
    input  logic                         ctrl_last,
    input  key_extract_pkg::phv_t        phv_out,
    input  logic                         phv_out_valid,
    input  key_extract_pkg::key_t        key_out,
    input  logic                         key_valid,
    input  key_extract_pkg::key_t        key_mask,
    output int                           mismatch_cnt,
    output int                           proto_cnt,
    output int                           pending
);

    localparam int KEY_W = key_extract_pkg::KEY_W;
    localparam int C6    = key_extract_pkg::CONT6_LSB;
    localparam int C4    = key_extract_pkg::CONT4_LSB;
    localparam int C2    = key_extract_pkg::CONT2_LSB;
    localparam int SEL   = key_extract_pkg::VLAN_LSB + 4;

    key_extract_pkg::key_off_t  off_tbl  [16];
    key_extract_pkg::key_t      mask_tbl [16];
    key_extract_pkg::key_t      exp_key  [$];
    key_extract_pkg::key_t      exp_mask [$];
    key_extract_pkg::phv_t      exp_phv  [$];
    key_extract_pkg::key_t      entry;
    // 0 idle, 1 offset burst, 2 mask burst
    logic [1:0]                 mode;
    logic [3:0]                 wr_idx;
    logic                       hdr_ok;
    // phv_valid of the last two edges
    logic [1:0]                 valid_pipe;

    assign hdr_ok = (ctrl_data[key_extract_pkg::MOD_ID_LSB +: 8] == {5'(STAGE_ID), KEY_EX_ID})
                 && (ctrl_data[key_extract_pkg::FLAG_LSB +: 16] == key_extract_pkg::CTRL_FLAG_KEY);

    // first beat byte lands at the top of the table entry
    function automatic key_extract_pkg::key_t beat_entry(input key_extract_pkg::ctrl_data_t d);
        key_extract_pkg::ctrl_data_t s;
        for (int b = 0; b < 64; b++) begin
            s[8*b +: 8] = d[504 - 8*b +: 8];
        end
        return s[511 -: KEY_W];
    endfunction

    function automatic key_extract_pkg::key_t model_key(input key_extract_pkg::phv_t p,
                                                        input logic cmp);
        key_extract_pkg::key_off_t o;
        key_extract_pkg::key_t     k;
        o = off_tbl[p[SEL +: 4]];
        k = '0;
        k[196 -: 48] = p[C6 + o[17:15] * 48 +: 48];
        k[148 -: 48] = p[C6 + o[14:12] * 48 +: 48];
        k[100 -: 32] = p[C4 + o[11:9] * 32 +: 32];
        k[68 -: 32]  = p[C4 + o[8:6] * 32 +: 32];
        k[36 -: 16]  = p[C2 + o[5:3] * 16 +: 16];
        k[20 -: 16]  = p[C2 + o[2:0] * 16 +: 16];
        k[4 - STAGE_ID] = cmp;
        return k;
    endfunction

    task automatic compare(input string name, input key_extract_pkg::phv_t exp,
                           input key_extract_pkg::phv_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
            mismatch_cnt++;
        end
    endtask

    initial begin
        mismatch_cnt = 0;
        proto_cnt    = 0;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode       = 2'd0;
            wr_idx     = '0;
            valid_pipe = '0;
            pending    = 0;
            exp_key.delete();
            exp_mask.delete();
            exp_phv.delete();
        end else begin
            // outputs follow phv_valid by two edges, key_out is zero between keys
            compare_bit("key_valid", valid_pipe[1], key_valid);
            compare_bit("phv_out_valid", valid_pipe[1], phv_out_valid);
            if (!key_valid) begin
                compare("key_out", '0, key_out);
            end
            valid_pipe = {valid_pipe[0], phv_valid};
            if (key_valid) begin
                if (exp_key.size() == 0) begin
                    $display("key_valid high at %0t with no PHV outstanding", $time);
                    proto_cnt++;
                end else begin
                    compare("key_out", exp_key.pop_front(), key_out);
                    compare("key_mask", exp_mask.pop_front(), key_mask);
                    compare("phv_out", exp_phv.pop_front(), phv_out);
                end
            end
            if (phv_valid) begin
                exp_key.push_back(model_key(phv_in, exp_cmp));
                exp_mask.push_back(mask_tbl[phv_in[SEL +: 4]]);
                exp_phv.push_back(phv_in);
            end
            if (ctrl_valid) begin
                entry = beat_entry(ctrl_data);
                if (mode == 2'd0) begin
                    if (hdr_ok) begin
                        mode   = (ctrl_data[key_extract_pkg::RESV_LSB +: 4] != 4'd0)
                               ? 2'd2 : 2'd1;
                        wr_idx = ctrl_data[key_extract_pkg::INDEX_LSB +: 4];
                    end
                end else begin
                    if (mode == 2'd1) begin
                        off_tbl[wr_idx] = entry[KEY_W-1 -: 18];
                    end else begin
                        mask_tbl[wr_idx] = entry;
                    end
                    wr_idx++;
                    if (ctrl_last) begin
                        mode = 2'd0;
                    end
                end
            end
            pending = exp_key.size();
        end
    end

endmodule

/* sim/key_extract_props.sv */
// key_extract_props: concurrent assertions on the key extractor output handshake
`timescale 1ns/1ns

module key_extract_props (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   phv_valid,
    input logic                   phv_out_valid,
    input logic                   key_valid,
    input key_extract_pkg::key_t  key_out
);

    // two register stages between phv_in and the outputs
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        phv_valid |-> ##2 (key_valid && phv_out_valid))
        else $error("accepted PHV did not come out two cycles later");

    a_key_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !key_valid |-> (key_out == '0))
        else $error("key_out nonzero while key_valid is low");

    a_valid_pair: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid == phv_out_valid)
        else $error("key_valid and phv_out_valid disagree");

endmodule

/* sim/tb_key_extract.sv */
// tb_key_extract: clock, reset, stimulus table and the loop that applies it to the DUT
`timescale 1ns/1ns

module tb_key_extract;

    localparam int         STAGE_ID  = 2;
    localparam logic [2:0] KEY_EX_ID = 3'd5;
    localparam int         KEY_W     = key_extract_pkg::KEY_W;
    localparam int         OP_MSB    = key_extract_pkg::OP_BASE - STAGE_ID * key_extract_pkg::OP_W;

    typedef enum logic [2:0] {K_IDLE, K_PHV, K_OFF, K_MASK, K_BAD_ID, K_BAD_FLAG} row_kind_t;

    // count is beats for a burst and cycles for idle, exp is the comparator bit
    typedef struct packed {
        row_kind_t         kind;
        logic [3:0]        entry;
        logic [2:0]        count;
        logic [KEY_W-1:0]  value;
        logic [19:0]       op;
        logic [7:0]        a;
        logic [7:0]        b;
        logic              exp;
    } row_t;

    logic                         clk;
    logic                         rst_n;
    key_extract_pkg::phv_t        phv_in;
    logic                         phv_valid;
    key_extract_pkg::ctrl_data_t  ctrl_data;
    logic                         ctrl_valid;
    logic                         ctrl_last;
    key_extract_pkg::phv_t        phv_out;
    logic                         phv_out_valid;
    key_extract_pkg::key_t        key_out;
    logic                         key_valid;
    key_extract_pkg::key_t        key_mask;
    logic                         exp_cmp;
    int                           mismatch_cnt;
    int                           proto_cnt;
    int                           pending;
    int                           timeout_cnt;
    logic [31:0]                  rng_state;
    row_t                         rows [$];

    key_extract #(.STAGE_ID(STAGE_ID), .KEY_EX_ID(KEY_EX_ID)) u_key_extract (.*);

    key_extract_checker #(.STAGE_ID(STAGE_ID), .KEY_EX_ID(KEY_EX_ID)) u_checker (.*);

    bind key_extract key_extract_props u_key_extract_props (.*);

    function logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic key_extract_pkg::ctrl_data_t reverse_bytes(
        input key_extract_pkg::ctrl_data_t d
    );
        key_extract_pkg::ctrl_data_t r;
        for (int b = 0; b < 64; b++) begin
            r[8*b +: 8] = d[504 - 8*b +: 8];
        end
        return r;
    endfunction

    function automatic logic [8:0] imm_opnd(input logic [7:0] v);
        return {1'b1, v};
    endfunction

    // size 2 is 6B, 1 is 4B, 0 is 2B, 3 reads as zero
    function automatic logic [8:0] cont_opnd(input logic [1:0] size, input logic [2:0] idx);
        return {4'b0000, size, idx};
    endfunction

    task automatic add_row(input row_kind_t kind, input logic [3:0] entry,
                           input logic [2:0] count, input logic [KEY_W-1:0] value,
                           input logic [19:0] op,
                           input logic [7:0] a, input logic [7:0] b, input logic exp);
        row_t r;
        r = {kind, entry, count, value, op, a, b, exp};
        rows.push_back(r);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_beat(input key_extract_pkg::ctrl_data_t d, input logic last);
        ctrl_data  = d;
        ctrl_valid = 1'b1;
        ctrl_last  = last;
        next_cycle();
        ctrl_valid = 1'b0;
        ctrl_last  = 1'b0;
    endtask

    task automatic send_burst(input row_t r);
        key_extract_pkg::ctrl_data_t hdr;
        key_extract_pkg::ctrl_data_t swapped;
        logic [KEY_W-1:0]            v;
        hdr = '0;
        hdr[key_extract_pkg::MOD_ID_LSB +: 8] = {5'(STAGE_ID), KEY_EX_ID}
                                              ^ ((r.kind == K_BAD_ID) ? 8'h08 : 8'h00);
        hdr[key_extract_pkg::FLAG_LSB +: 16]  = (r.kind == K_BAD_FLAG) ? 16'hf2f0
                                              : key_extract_pkg::CTRL_FLAG_KEY;
        hdr[key_extract_pkg::RESV_LSB +: 4]   = (r.kind == K_MASK) ? 4'h3 : 4'h0;
        hdr[key_extract_pkg::INDEX_LSB +: 8]  = 8'(r.entry);
        send_beat(hdr, 1'b0);
        v = r.value;
        for (int j = 0; j < r.count; j++) begin
            swapped = '0;
            if (r.kind == K_MASK) begin
                swapped[511 -: KEY_W] = v;
                v = {v[KEY_W-4:0], v[KEY_W-1 -: 3]};
            end else begin
                swapped[511 -: 18] = v[17:0];
                // next entry gets its container indices rotated by one field
                v[17:0] = {v[14:0], v[17:15]};
            end
            send_beat(reverse_bytes(swapped), j == r.count - 1);
        end
    endtask

    task automatic set_operand(inout key_extract_pkg::phv_t p, input logic [8:0] fld,
                               input logic [7:0] val);
        if (!fld[8]) begin
            case (fld[4:3])
                2'b10:   p[key_extract_pkg::CONT6_LSB + int'(fld[2:0]) * 48 +: 8] = val;
                2'b01:   p[key_extract_pkg::CONT4_LSB + int'(fld[2:0]) * 32 +: 8] = val;
                2'b00:   p[key_extract_pkg::CONT2_LSB + int'(fld[2:0]) * 16 +: 8] = val;
                default: ;
            endcase
        end
    endtask

    task automatic send_phv(input row_t r);
        logic [36*32-1:0]       raw;
        key_extract_pkg::phv_t  p;
        for (int w = 0; w < 36; w++) begin
            raw[32*w +: 32] = next_rand();
        end
        p = key_extract_pkg::phv_t'(raw);
        p[key_extract_pkg::VLAN_LSB + 4 +: 4] = r.entry;
        p[OP_MSB -: 20] = r.op;
        set_operand(p, r.op[17:9], r.a);
        set_operand(p, r.op[8:0], r.b);
        phv_in    = p;
        phv_valid = 1'b1;
        exp_cmp   = r.exp;
        next_cycle();
        phv_valid = 1'b0;
    endtask

    task automatic build_table();
        add_row(K_IDLE, 0, 6, '0, '0, 0, 0, 0);
        add_row(K_OFF, 3, 3, {3'd1, 3'd6, 3'd2, 3'd5, 3'd0, 3'd7}, '0, 0, 0, 0);
        add_row(K_MASK, 3, 3, {{24{8'hc3}}, 5'b10110}, '0, 0, 0, 0);
        add_row(K_IDLE, 0, 4, '0, '0, 0, 0, 0);
        // comparator cases on back-to-back PHVs across entries 3 to 5
        add_row(K_PHV, 3, 0, '0, {2'd0, imm_opnd(8'h40), imm_opnd(8'h30)}, 0, 0, 1);
        add_row(K_PHV, 4, 0, '0, {2'd0, imm_opnd(8'h30), imm_opnd(8'h40)}, 0, 0, 0);
        add_row(K_PHV, 5, 0, '0, {2'd1, imm_opnd(8'h30), imm_opnd(8'h30)}, 0, 0, 1);
        add_row(K_PHV, 3, 0, '0, {2'd2, cont_opnd(2, 1), imm_opnd(8'h55)}, 8'h55, 0, 1);
        add_row(K_PHV, 4, 0, '0, {2'd1, cont_opnd(1, 2), cont_opnd(0, 5)}, 8'h10, 8'h11, 0);
        add_row(K_PHV, 5, 0, '0, {2'd2, cont_opnd(0, 0), cont_opnd(1, 7)}, 8'h22, 8'h22, 1);
        add_row(K_PHV, 3, 0, '0, {2'd0, cont_opnd(3, 0), imm_opnd(8'h00)}, 8'h99, 0, 0);
        add_row(K_PHV, 4, 0, '0, {2'd1, cont_opnd(3, 4), imm_opnd(8'h01)}, 8'h99, 0, 0);
        add_row(K_PHV, 5, 0, '0, {2'd3, cont_opnd(2, 3), imm_opnd(8'hff)}, 8'h01, 0, 1);
        add_row(K_PHV, 3, 0, '0, {2'd0, cont_opnd(1, 0), cont_opnd(2, 2)}, 8'h80, 8'h7f, 1);
        add_row(K_IDLE, 0, 3, '0, '0, 0, 0, 0);
        // rejected headers, their beats must not reach the tables
        add_row(K_BAD_ID, 3, 2, {6{3'd4}}, '0, 0, 0, 0);
        add_row(K_BAD_FLAG, 4, 2, {6{3'd3}}, '0, 0, 0, 0);
        add_row(K_IDLE, 0, 4, '0, '0, 0, 0, 0);
        add_row(K_PHV, 3, 0, '0, {2'd3, imm_opnd(8'h00), imm_opnd(8'h00)}, 0, 0, 1);
        add_row(K_PHV, 4, 0, '0, {2'd2, cont_opnd(2, 7), cont_opnd(2, 6)}, 8'h07, 8'h09, 0);
        add_row(K_PHV, 5, 0, '0, {2'd3, imm_opnd(8'h00), imm_opnd(8'h00)}, 0, 0, 1);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        int wait_cnt;
        rst_n       = 1'b0;
        phv_in      = '0;
        phv_valid   = 1'b0;
        exp_cmp     = 1'b0;
        ctrl_data   = '0;
        ctrl_valid  = 1'b0;
        ctrl_last   = 1'b0;
        rng_state   = 32'd36132;
        timeout_cnt = 0;
        build_table();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (rows[i]) begin
            case (rows[i].kind)
                K_IDLE:  repeat (rows[i].count) next_cycle();
                K_PHV:   send_phv(rows[i]);
                default: send_burst(rows[i]);
            endcase
        end
        wait_cnt = 0;
        while (pending != 0 && wait_cnt < 50) begin
            next_cycle();
            wait_cnt++;
        end
        if (pending != 0) begin
            $display("timeout: %0d expected keys never came out", pending);
            timeout_cnt++;
        end
        repeat (3) next_cycle();
        $display("errors: mismatch %0d, protocol %0d, timeout %0d",
                 mismatch_cnt, proto_cnt, timeout_cnt);
        if (mismatch_cnt + proto_cnt + timeout_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/key_extract_pkg.sv
common/table_wr_if.sv
hdl/cfg_writer.sv
hdl/key_table_ram.sv
key_build/key_assembler.sv
hdl/key_extract.sv
sim/key_extract_props.sv
sim/key_extract_checker.sv
sim/tb_key_extract.sv
